/* all.f */
+incdir+include
hw/dcache_pkg.sv
hw/dcache_req_buf.sv
hw/dcache_tagv.sv
hw/dcache_data.sv
hw/dcache_lru.sv
hw/dcache_fsm.sv
hw/dcache_top.sv
verification/tb_mem_model.sv
verification/tb_dcache.sv

/* hw/dcache_data.sv */
`timescale 1ns/1ps
`include "dcache_macros.svh"

module dcache_data (
    input  logic                  clk,
    input  dcache_pkg::index_t    rd_index,
    input  logic                  sel_way,
    input  dcache_pkg::offset_t   sel_offset,
    output dcache_pkg::word_t     rd_word,
    input  dcache_pkg::way_mask_t refill_en,
    input  dcache_pkg::way_mask_t word_en,
    input  dcache_pkg::index_t    wr_index,
    input  dcache_pkg::offset_t   wr_offset,
    input  dcache_pkg::line_t     refill_line,
    input  dcache_pkg::word_t     wr_word,
    input  dcache_pkg::strb_t     wr_strb
);

    // word organized so a strobed write touches one entry
    dcache_pkg::word_t ram [`DCACHE_WAYS][1 << `DCACHE_INDEX_W][`DCACHE_LINE_WORDS];
    dcache_pkg::line_t rd_line [`DCACHE_WAYS];

    ////////////////////////////////////////////////////
    // writes and registered line read
    ////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        for (int w = 0; w < `DCACHE_WAYS; w++) begin
            if (refill_en[w]) begin
                for (int k = 0; k < `DCACHE_LINE_WORDS; k++) begin
                    ram[w][wr_index][k] <= refill_line[32*k +: 32];
                end
            end else if (word_en[w]) begin
                // byte merge on a write hit
                for (int b = 0; b < $bits(dcache_pkg::strb_t); b++) begin
                    if (wr_strb[b]) begin
                        ram[w][wr_index][wr_offset][8*b +: 8] <= wr_word[8*b +: 8];
                    end
                end
            end

            for (int k = 0; k < `DCACHE_LINE_WORDS; k++) begin
                rd_line[w][32*k +: 32] <= ram[w][rd_index][k];
            end
        end
    end

    ////////////////////////////////////////////////////
    // output word select
    ////////////////////////////////////////////////////
    always_comb begin
        rd_word = rd_line[sel_way][32*sel_offset +: 32];
    end

endmodule

/* hw/dcache_fsm.sv */
`timescale 1ns/1ps
`include "dcache_macros.svh"

module dcache_fsm (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  req_valid,
    output logic                  req_ready,
    input  logic                  buf_wr,
    input  dcache_pkg::way_mask_t hit,
    input  logic                  victim,
    output logic                  mem_req_valid,
    input  logic                  mem_req_ready,
    input  logic                  mem_rvalid,
    output logic                  resp_valid,
    output logic                  load,
    output logic                  lru_touch,
    output logic                  lru_way,
    output dcache_pkg::way_mask_t tag_we,
    output dcache_pkg::way_mask_t refill_en,
    output dcache_pkg::way_mask_t word_en,
    output logic                  sel_way,
    output logic                  use_refill
);

    dcache_pkg::fsm_state_t state;
    dcache_pkg::fsm_state_t state_nxt;
    dcache_pkg::way_mask_t  victim_mask;
    logic                   hit_any;

    assign hit_any     = |hit;
    assign victim_mask = dcache_pkg::way_mask_t'(1) << victim;
    assign load        = req_valid && req_ready;  // request accepted this edge
    assign tag_we      = refill_en;               // new tag goes with the line

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= dcache_pkg::IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    ////////////////////////////////////////////////////
    // next state and outputs
    ////////////////////////////////////////////////////
    always_comb begin
        state_nxt     = state;
        req_ready     = 1'b0;
        mem_req_valid = 1'b0;
        resp_valid    = 1'b0;
        lru_touch     = 1'b0;
        lru_way       = 1'b0;
        refill_en     = '0;
        word_en       = '0;
        sel_way       = 1'b0;
        use_refill    = 1'b0;

        case (state)
            dcache_pkg::IDLE: begin
                req_ready = 1'b1;
                if (req_valid) begin
                    state_nxt = dcache_pkg::LOOKUP;
                end
            end

            dcache_pkg::LOOKUP: begin
                lru_touch = hit_any;
                lru_way   = hit[1];
                if (buf_wr) begin
                    word_en   = hit;  // merge only when cached
                    state_nxt = dcache_pkg::WRITE_REQ;
                end else if (hit_any) begin
                    // read hit, pipelined with the next request
                    resp_valid = 1'b1;
                    sel_way    = hit[1];
                    req_ready  = 1'b1;
                    state_nxt  = req_valid ? dcache_pkg::LOOKUP : dcache_pkg::IDLE;
                end else begin
                    state_nxt = dcache_pkg::REFILL_REQ;
                end
            end

            dcache_pkg::REFILL_REQ: begin
                mem_req_valid = 1'b1;  // line read, held until accepted
                if (mem_req_ready) begin
                    state_nxt = dcache_pkg::REFILL_WAIT;
                end
            end

            dcache_pkg::REFILL_WAIT: begin
                if (mem_rvalid) begin
                    refill_en = victim_mask;
                    lru_touch = 1'b1;
                    lru_way   = victim;
                    state_nxt = dcache_pkg::RESP;
                end
            end

            dcache_pkg::WRITE_REQ: begin
                mem_req_valid = 1'b1;
                if (mem_req_ready) begin
                    state_nxt = dcache_pkg::IDLE;
                end
            end

            dcache_pkg::RESP: begin
                resp_valid = 1'b1;
                use_refill = 1'b1;  // word comes from the fetched line
                req_ready  = 1'b1;
                state_nxt  = req_valid ? dcache_pkg::LOOKUP : dcache_pkg::IDLE;
            end

            default: begin
                state_nxt = dcache_pkg::IDLE;
            end
        endcase
    end

endmodule

/* hw/dcache_lru.sv */
`timescale 1ns/1ps
`include "dcache_macros.svh"

module dcache_lru (
    input  logic               clk,
    input  logic               rst,
    input  dcache_pkg::index_t index,
    input  logic               touch,
    input  logic               touched_way,
    output logic               victim
);

    logic [(1<<`DCACHE_INDEX_W)-1:0] lru_bits;  // names the least recent way

    always_ff @(posedge clk) begin
        if (rst) begin
            lru_bits <= '0;
        end else if (touch) begin
            lru_bits[index] <= ~touched_way;  // other way becomes victim
        end
    end

    assign victim = lru_bits[index];

endmodule

/* hw/dcache_pkg.sv */
`include "dcache_macros.svh"

package dcache_pkg;

    typedef logic [31:0] addr_t;   // byte address
    typedef logic [31:0] word_t;
    typedef logic [3:0]  strb_t;   // one bit per byte lane

    typedef logic [`DCACHE_INDEX_W-1:0]  index_t;
    typedef logic [`DCACHE_OFFSET_W-1:0] offset_t;

    // address minus index, word offset and byte offset
    typedef logic [31-`DCACHE_INDEX_W-`DCACHE_OFFSET_W-2:0] tag_t;

    typedef logic [32*`DCACHE_LINE_WORDS-1:0] line_t;
    typedef logic [`DCACHE_WAYS-1:0]          way_mask_t;

    // controller states
    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        REFILL_REQ,
        REFILL_WAIT,
        WRITE_REQ,
        RESP
    } fsm_state_t;

endpackage

/* hw/dcache_req_buf.sv */
`timescale 1ns/1ps
`include "dcache_macros.svh"

module dcache_req_buf (
    input  logic                clk,
    input  logic                rst,
    input  logic                load,
    input  logic                req_wr,
    input  dcache_pkg::addr_t   req_addr,
    input  dcache_pkg::word_t   req_wdata,
    input  dcache_pkg::strb_t   req_wstrb,
    output logic                buf_wr,
    output dcache_pkg::addr_t   buf_addr,
    output dcache_pkg::word_t   buf_wdata,
    output dcache_pkg::strb_t   buf_wstrb,
    output dcache_pkg::index_t  buf_index,
    output dcache_pkg::offset_t buf_offset,
    output dcache_pkg::tag_t    buf_tag
);

    always_ff @(posedge clk) begin
        if (rst) begin
            buf_wr <= 1'b0;
        end else if (load) begin
            buf_wr <= req_wr;
        end
    end

    // payload only changes on an accepted request
    always_ff @(posedge clk) begin
        if (load) begin
            buf_addr  <= req_addr;
            buf_wdata <= req_wdata;
            buf_wstrb <= req_wstrb;
        end
    end

    // address fields, bits [1:0] are the byte lane
    assign buf_offset = buf_addr[`DCACHE_OFFSET_W+1:2];
    assign buf_index  = buf_addr[`DCACHE_OFFSET_W+`DCACHE_INDEX_W+1:`DCACHE_OFFSET_W+2];
    assign buf_tag    = buf_addr[31:`DCACHE_OFFSET_W+`DCACHE_INDEX_W+2];

endmodule

/* hw/dcache_tagv.sv */
`timescale 1ns/1ps
`include "dcache_macros.svh"

module dcache_tagv (
    input  logic                  clk,
    input  logic                  rst,
    input  dcache_pkg::index_t    rd_index,
    input  dcache_pkg::tag_t      cmp_tag,
    output dcache_pkg::way_mask_t hit,
    input  dcache_pkg::way_mask_t wr_en,
    input  dcache_pkg::index_t    wr_index,
    input  dcache_pkg::tag_t      wr_tag
);

    dcache_pkg::tag_t              tag_ram [`DCACHE_WAYS][1 << `DCACHE_INDEX_W];
    logic [(1<<`DCACHE_INDEX_W)-1:0] valid [`DCACHE_WAYS];   // one bit per set
    dcache_pkg::tag_t              tag_q [`DCACHE_WAYS];
    dcache_pkg::way_mask_t         valid_q;

    ////////////////////////////////////////////////////
    // tag storage, written on refill only
    ////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        for (int w = 0; w < `DCACHE_WAYS; w++) begin
            if (wr_en[w]) begin
                tag_ram[w][wr_index] <= wr_tag;
            end
            tag_q[w] <= tag_ram[w][rd_index];  // registered read
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int w = 0; w < `DCACHE_WAYS; w++) begin
                valid[w] <= '0;
            end
            valid_q <= '0;
        end else begin
            for (int w = 0; w < `DCACHE_WAYS; w++) begin
                if (wr_en[w]) begin
                    valid[w][wr_index] <= 1'b1;
                end
                valid_q[w] <= valid[w][rd_index];
            end
        end
    end

    // compare in the cycle after the read
    always_comb begin
        for (int w = 0; w < `DCACHE_WAYS; w++) begin
            hit[w] = valid_q[w] && (tag_q[w] == cmp_tag);
        end
    end

endmodule

/* hw/dcache_top.sv */
`timescale 1ns/1ps
`include "dcache_macros.svh"

module dcache_top (
    input  logic              clk,
    input  logic              rst,
    // pipeline side
    input  logic              req_valid,
    output logic              req_ready,
    input  logic              req_wr,
    input  dcache_pkg::addr_t req_addr,
    input  dcache_pkg::word_t req_wdata,
    input  dcache_pkg::strb_t req_wstrb,
    output logic              resp_valid,
    output dcache_pkg::word_t resp_data,
    // memory side
    output logic              mem_req_valid,
    input  logic              mem_req_ready,
    output logic              mem_wr,
    output dcache_pkg::addr_t mem_addr,
    output dcache_pkg::word_t mem_wdata,
    output dcache_pkg::strb_t mem_wstrb,
    input  logic              mem_rvalid,
    input  dcache_pkg::line_t mem_rline
);

    logic                  load;
    logic                  buf_wr;
    dcache_pkg::addr_t     buf_addr;
    dcache_pkg::word_t     buf_wdata;
    dcache_pkg::strb_t     buf_wstrb;
    dcache_pkg::index_t    buf_index;
    dcache_pkg::offset_t   buf_offset;
    dcache_pkg::tag_t      buf_tag;
    dcache_pkg::index_t    req_index;
    dcache_pkg::way_mask_t hit;
    dcache_pkg::way_mask_t tag_we;
    dcache_pkg::way_mask_t refill_en;
    dcache_pkg::way_mask_t word_en;
    logic                  victim;
    logic                  lru_touch;
    logic                  lru_way;
    logic                  sel_way;
    logic                  use_refill;
    dcache_pkg::word_t     rd_word;
    dcache_pkg::word_t     refill_word;

    // arrays read the incoming set on the accept edge
    assign req_index = req_addr[`DCACHE_OFFSET_W+`DCACHE_INDEX_W+1:`DCACHE_OFFSET_W+2];

    dcache_req_buf i_req_buf (
        .clk        (clk),
        .rst        (rst),
        .load       (load),
        .req_wr     (req_wr),
        .req_addr   (req_addr),
        .req_wdata  (req_wdata),
        .req_wstrb  (req_wstrb),
        .buf_wr     (buf_wr),
        .buf_addr   (buf_addr),
        .buf_wdata  (buf_wdata),
        .buf_wstrb  (buf_wstrb),
        .buf_index  (buf_index),
        .buf_offset (buf_offset),
        .buf_tag    (buf_tag)
    );

    dcache_tagv i_tagv (
        .clk      (clk),
        .rst      (rst),
        .rd_index (req_index),
        .cmp_tag  (buf_tag),
        .hit      (hit),
        .wr_en    (tag_we),
        .wr_index (buf_index),
        .wr_tag   (buf_tag)
    );

    dcache_data i_data (
        .clk         (clk),
        .rd_index    (req_index),
        .sel_way     (sel_way),
        .sel_offset  (buf_offset),
        .rd_word     (rd_word),
        .refill_en   (refill_en),
        .word_en     (word_en),
        .wr_index    (buf_index),
        .wr_offset   (buf_offset),
        .refill_line (mem_rline),
        .wr_word     (buf_wdata),
        .wr_strb     (buf_wstrb)
    );

    dcache_lru i_lru (
        .clk         (clk),
        .rst         (rst),
        .index       (buf_index),
        .touch       (lru_touch),
        .touched_way (lru_way),
        .victim      (victim)
    );

    dcache_fsm i_fsm (
        .clk           (clk),
        .rst           (rst),
        .req_valid     (req_valid),
        .req_ready     (req_ready),
        .buf_wr        (buf_wr),
        .hit           (hit),
        .victim        (victim),
        .mem_req_valid (mem_req_valid),
        .mem_req_ready (mem_req_ready),
        .mem_rvalid    (mem_rvalid),
        .resp_valid    (resp_valid),
        .load          (load),
        .lru_touch     (lru_touch),
        .lru_way       (lru_way),
        .tag_we        (tag_we),
        .refill_en     (refill_en),
        .word_en       (word_en),
        .sel_way       (sel_way),
        .use_refill    (use_refill)
    );

    ////////////////////////////////////////////////////
    // memory request fields
    ////////////////////////////////////////////////////
    assign mem_wr    = buf_wr;
    assign mem_wdata = buf_wdata;
    assign mem_wstrb = buf_wstrb;
    // line reads go out aligned
    assign mem_addr  = buf_wr ? buf_addr
                              : {buf_addr[31:`DCACHE_OFFSET_W+2], {(`DCACHE_OFFSET_W+2){1'b0}}};

    ////////////////////////////////////////////////////
    // response word
    ////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (mem_rvalid) begin
            refill_word <= mem_rline[32*buf_offset +: 32];  // mem_rline lasts one cycle
        end
    end

    assign resp_data = use_refill ? refill_word : rd_word;

endmodule

/* include/dcache_macros.svh */
`ifndef DCACHE_MACROS_SVH
`define DCACHE_MACROS_SVH

////////////////////////////////////////////////////
// cache geometry
////////////////////////////////////////////////////

// set index bits, 16 sets
`define DCACHE_INDEX_W 4

// word-in-line bits
`define DCACHE_OFFSET_W 2

// words per line, 2**DCACHE_OFFSET_W
`define DCACHE_LINE_WORDS 4

// fixed at two, the lru bit and hit compare rely on it
`define DCACHE_WAYS 2

`endif

/* verification/tb_dcache.sv */
`timescale 1ns/1ps

module tb_dcache;

    localparam int WAIT_LIMIT = 200;

    logic              clk;
    logic              rst;
    logic              req_valid;
    logic              req_ready;
    logic              req_wr;
    dcache_pkg::addr_t req_addr;
    dcache_pkg::word_t req_wdata;
    dcache_pkg::strb_t req_wstrb;
    logic              resp_valid;
    dcache_pkg::word_t resp_data;
    logic              mem_req_valid;
    logic              mem_req_ready;
    logic              mem_wr;
    dcache_pkg::addr_t mem_addr;
    dcache_pkg::word_t mem_wdata;
    dcache_pkg::strb_t mem_wstrb;
    logic              mem_rvalid;
    dcache_pkg::line_t mem_rline;

    // fields of the last accepted request
    dcache_pkg::addr_t acc_addr;
    dcache_pkg::word_t acc_wdata;
    dcache_pkg::strb_t acc_wstrb;
    dcache_pkg::word_t exp_data;
    logic              rd_pending;
    logic              expect_hit;
    logic              accept;
    logic              timed_out;
    logic [7:0]        shadow [0:4095];
    int                errors;

    assign accept = req_valid && req_ready;

    dcache_top i_dcache_top (
        .clk           (clk),
        .rst           (rst),
        .req_valid     (req_valid),
        .req_ready     (req_ready),
        .req_wr        (req_wr),
        .req_addr      (req_addr),
        .req_wdata     (req_wdata),
        .req_wstrb     (req_wstrb),
        .resp_valid    (resp_valid),
        .resp_data     (resp_data),
        .mem_req_valid (mem_req_valid),
        .mem_req_ready (mem_req_ready),
        .mem_wr        (mem_wr),
        .mem_addr      (mem_addr),
        .mem_wdata     (mem_wdata),
        .mem_wstrb     (mem_wstrb),
        .mem_rvalid    (mem_rvalid),
        .mem_rline     (mem_rline)
    );

    tb_mem_model i_mem_model (
        .clk           (clk),
        .rst           (rst),
        .mem_req_valid (mem_req_valid),
        .mem_req_ready (mem_req_ready),
        .mem_wr        (mem_wr),
        .mem_addr      (mem_addr),
        .mem_wdata     (mem_wdata),
        .mem_wstrb     (mem_wstrb),
        .mem_rvalid    (mem_rvalid),
        .mem_rline     (mem_rline)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    task automatic report_check(input string msg);
        errors++;
        $display("CHECK FAILED at %0t: %s", $time, msg);
    endtask

    ////////////////////////////////////////////////////
    // protocol and data checks
    ////////////////////////////////////////////////////
    a_hit_latency: assert property (@(posedge clk) disable iff (rst)
        accept && !req_wr && expect_hit |=> resp_valid && !mem_req_valid)
        else report_check("read hit not answered one cycle after acceptance");

    a_miss_fetch: assert property (@(posedge clk) disable iff (rst)
        accept && !req_wr && !expect_hit |=> !resp_valid ##1 (mem_req_valid && !mem_wr))
        else report_check("read miss did not issue a line read");

    a_line_addr: assert property (@(posedge clk) disable iff (rst)
        mem_req_valid && !mem_wr |-> mem_addr == {acc_addr[31:4], 4'h0})
        else report_check("line read address not the aligned request address");

    a_write_issue: assert property (@(posedge clk) disable iff (rst)
        accept && req_wr |=> !mem_req_valid ##1 (mem_req_valid && mem_wr))
        else report_check("write not sent to memory as a write");

    a_write_fields: assert property (@(posedge clk) disable iff (rst)
        mem_req_valid && mem_wr |->
            mem_addr == acc_addr && mem_wdata == acc_wdata && mem_wstrb == acc_wstrb)
        else report_check("write-through fields differ from the request");

    a_resp_data: assert property (@(posedge clk) disable iff (rst)
        resp_valid |-> rd_pending && resp_data == exp_data)
        else report_check("response data differs from shadow memory");

    a_hold: assert property (@(posedge clk) disable iff (rst)
        mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_wr)
            && $stable(mem_addr) && $stable(mem_wdata) && $stable(mem_wstrb))
        else report_check("memory request changed while stalled");

    a_no_accept: assert property (@(posedge clk) disable iff (rst)
        mem_req_valid |-> !req_ready)
        else report_check("req_ready high during a memory request");

    a_once: assert property (@(posedge clk) disable iff (rst)
        mem_req_valid && mem_req_ready |=> !mem_req_valid)
        else report_check("memory request issued more than once");

    // same address pattern as the memory model
    function automatic logic [7:0] fill_byte(input logic [31:0] a);
        logic [31:0] m;
        m = (a ^ 32'h6A09_E667) * 32'h9E37_79B1;
        return m[31:24];
    endfunction

    function automatic dcache_pkg::word_t shadow_word(input dcache_pkg::addr_t a);
        dcache_pkg::word_t w;
        for (int b = 0; b < 4; b++) begin
            w[8*b +: 8] = shadow[{a[11:2], 2'(b)}];
        end
        return w;
    endfunction

    task automatic report_timeout(input string why);
        $display("%s", why);
        timed_out = 1'b1;
    endtask

    // ends the run once any wait has expired
    initial begin
        wait (timed_out);
        $display("errors: %0d", errors);
        $display("Simulation failed");
        $finish;
    end

    task automatic issue(input logic wr, input dcache_pkg::addr_t a,
                         input dcache_pkg::word_t d, input dcache_pkg::strb_t s,
                         input logic hit);
        int t;
        t = 0;
        @(posedge clk);
        req_valid  <= 1'b1;
        req_wr     <= wr;
        req_addr   <= a;
        req_wdata  <= d;
        req_wstrb  <= s;
        expect_hit <= hit;
        @(negedge clk);
        while (!req_ready && t < WAIT_LIMIT) begin
            @(negedge clk);
            t++;
        end
        if (!req_ready) begin
            report_timeout("timeout: the cache never accepted the request");
        end
        @(posedge clk);  // accept edge
        req_valid <= 1'b0;
        acc_addr  <= a;
        acc_wdata <= d;
        acc_wstrb <= s;
        if (wr) begin
            for (int b = 0; b < 4; b++) begin
                if (s[b]) begin
                    shadow[{a[11:2], 2'(b)}] = d[8*b +: 8];
                end
            end
        end else begin
            exp_data   <= shadow_word(a);
            rd_pending <= 1'b1;
        end
    endtask

    task automatic read_word(input dcache_pkg::addr_t a, input logic hit);
        int t;
        t = 0;
        issue(1'b0, a, '0, '0, hit);
        @(negedge clk);
        while (!resp_valid && t < WAIT_LIMIT) begin
            @(negedge clk);
            t++;
        end
        if (!resp_valid) begin
            report_timeout("timeout: no response to a read");
        end
        @(posedge clk);
        rd_pending <= 1'b0;
    endtask

    ////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////
    initial begin
        errors     = 0;
        timed_out  = 1'b0;
        rst        = 1'b1;
        req_valid  = 1'b0;
        req_wr     = 1'b0;
        req_addr   = '0;
        req_wdata  = '0;
        req_wstrb  = '0;
        expect_hit = 1'b0;
        rd_pending = 1'b0;
        acc_addr   = '0;
        acc_wdata  = '0;
        acc_wstrb  = '0;
        exp_data   = '0;
        for (int i = 0; i < 4096; i++) begin
            shadow[i] = fill_byte(32'(i));
        end
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        read_word(32'h0000_0124, 1'b0);                     // cold miss, set 2
        read_word(32'h0000_0128, 1'b1);                     // same line hits
        issue(1'b1, 32'h0000_0124, 32'hA1B2_C3D4, 4'b0101, 1'b0);
        read_word(32'h0000_0124, 1'b1);                     // merged bytes
        issue(1'b1, 32'h0000_0338, 32'h1357_9BDF, 4'b1110, 1'b0);
        read_word(32'h0000_0338, 1'b0);                     // no write allocate

        // set 5, tags A B A C then A hits and B is gone
        read_word(32'h0000_0050, 1'b0);
        read_word(32'h0000_0150, 1'b0);
        read_word(32'h0000_0054, 1'b1);
        read_word(32'h0000_0250, 1'b0);
        read_word(32'h0000_005C, 1'b1);
        read_word(32'h0000_0158, 1'b0);

        repeat (4) @(posedge clk);
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* verification/tb_mem_model.sv */
`timescale 1ns/1ps

module tb_mem_model (
    input  logic              clk,
    input  logic              rst,
    input  logic              mem_req_valid,
    output logic              mem_req_ready,
    input  logic              mem_wr,
    input  dcache_pkg::addr_t mem_addr,
    input  dcache_pkg::word_t mem_wdata,
    input  dcache_pkg::strb_t mem_wstrb,
    output logic              mem_rvalid,
    output dcache_pkg::line_t mem_rline
);

    localparam logic [31:0] SEED = 32'h6202_7195;

    logic [7:0]  store [0:4095];  // 4 KB window, addr[11:0]
    logic [31:0] seed;
    logic        armed;           // acceptance delay drawn for this request
    logic [1:0]  accept_cnt;
    logic        read_pending;
    logic [1:0]  read_cnt;
    logic [11:0] read_base;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // product mixes every address bit into the top byte
    function automatic logic [7:0] fill_byte(input logic [31:0] a);
        logic [31:0] m;
        m = (a ^ 32'h6A09_E667) * 32'h9E37_79B1;
        return m[31:24];
    endfunction

    initial begin
        mem_req_ready = 1'b0;
        mem_rvalid    = 1'b0;
        mem_rline     = '0;
        for (int i = 0; i < 4096; i++) begin
            store[i] = fill_byte(32'(i));
        end
    end

    ////////////////////////////////////////////////////
    // request acceptance and read return
    ////////////////////////////////////////////////////
    always @(posedge clk) begin
        if (rst) begin
            seed          <= SEED;
            mem_req_ready <= 1'b0;
            mem_rvalid    <= 1'b0;
            armed         <= 1'b0;
            accept_cnt    <= '0;
            read_pending  <= 1'b0;
            read_cnt      <= '0;
            read_base     <= '0;
        end else begin
            mem_rvalid <= 1'b0;  // one-cycle pulse
            if (mem_req_valid && mem_req_ready) begin
                mem_req_ready <= 1'b0;
                armed         <= 1'b0;
                if (mem_wr) begin
                    for (int b = 0; b < 4; b++) begin
                        if (mem_wstrb[b]) begin
                            store[{mem_addr[11:2], 2'(b)}] <= mem_wdata[8*b +: 8];
                        end
                    end
                end else begin
                    read_pending <= 1'b1;
                    read_base    <= {mem_addr[11:4], 4'h0};
                    read_cnt     <= seed[21:20];  // return latency
                    seed         <= lcg_next(seed);
                end
            end else if (mem_req_valid && !armed) begin
                armed      <= 1'b1;
                accept_cnt <= seed[25:24];
                seed       <= lcg_next(seed);
            end else if (mem_req_valid && !mem_req_ready) begin
                if (accept_cnt == 0) begin
                    mem_req_ready <= 1'b1;
                end else begin
                    accept_cnt <= accept_cnt - 1'b1;
                end
            end

            if (read_pending) begin
                if (read_cnt == 0) begin
                    mem_rvalid   <= 1'b1;
                    read_pending <= 1'b0;
                    for (int k = 0; k < 16; k++) begin
                        mem_rline[8*k +: 8] <= store[read_base + 12'(k)];
                    end
                end else begin
                    read_cnt <= read_cnt - 1'b1;
                end
            end
        end
    end

endmodule
